// File: include/dma_xif_consts.svh
// DMA instruction decoder constants.
// Data and address widths, instruction field offsets,
// opcodes, SET func3 codes and front-end register offsets.

`ifndef DMA_XIF_CONSTS_SVH
`define DMA_XIF_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DMA_DATA_W          32  // Register and operand width.
`define DMA_ADDR_W          32  // Register bus address.
`define DMA_INSTR_W         32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DMA_OPCODE_OFF      0
`define DMA_OPCODE_W        7
`define DMA_FUNC3_OFF       12
`define DMA_FUNC3_W         3

// Single-bit CONF options.
`define DMA_DIRECTION_OFF   25
`define DMA_DEC_RW_OFF      26  // Decouple read and write.
`define DMA_DEC_AW_OFF      27  // Decouple read and AW.

// Custom opcode space.
`define DMA_CONF_OPCODE     7'b101_1011
`define DMA_SET_OPCODE      7'b111_1011

// SET func3 codes.
`define DMA_SET_DA_FUNC3    3'd0  // Destination address.
`define DMA_SET_SA_FUNC3    3'd1  // Source address.
`define DMA_SET_L_FUNC3     3'd2  // Length.
`define DMA_SET_S_FUNC3     3'd3  // Start.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Front-end register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DMA_REG_CONF_OFF    32'h0000_0000
`define DMA_REG_DST_OFF     32'h0000_0008
`define DMA_REG_SRC_OFF     32'h0000_0010
`define DMA_REG_LEN_OFF     32'h0000_0018
`define DMA_REG_NEXT_ID_OFF 32'h0000_0020  // Read launches, then polls.

`endif

// File: rtl/dma_xif_pkg.sv
// DMA instruction decoder types.
// Issue channel structs, stored configuration,
// front-end register bus structs and sequencer states.

`include "dma_xif_consts.svh"

package dma_xif_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Issue channel
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [`DMA_INSTR_W-1:0] instr;
    logic [`DMA_DATA_W-1:0]  rs0;       // First source operand.
    logic                    rs_valid;
  } xif_issue_req_t;

  typedef struct packed {
    logic accept;
  } xif_issue_rsp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Transfer configuration
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic direction;    // 0: AXI to OBI, 1: OBI to AXI.
    logic decouple_rw;
    logic decouple_aw;
  } dma_conf_t;

  typedef struct packed {
    dma_conf_t              conf;
    logic [`DMA_DATA_W-1:0] dst;
    logic [`DMA_DATA_W-1:0] src;
    logic [`DMA_DATA_W-1:0] len;
  } dma_cfg_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Front-end register bus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [`DMA_ADDR_W-1:0]   addr;
    logic                     write;
    logic [`DMA_DATA_W-1:0]   wdata;
    logic [`DMA_DATA_W/8-1:0] wstrb;
    logic                     valid;
  } fe_reg_req_t;

  typedef struct packed {
    logic [`DMA_DATA_W-1:0] rdata;
    logic                   error;
    logic                   ready;
  } fe_reg_rsp_t;

  typedef enum logic [3:0] {
    IDLE    = 4'd0,
    WR_CONF = 4'd1,
    WR_DST  = 4'd2,
    WR_SRC  = 4'd3,
    WR_LEN  = 4'd4,
    START   = 4'd5,
    BUSY    = 4'd6,
    DONE    = 4'd7
  } fe_seq_state_e;

endpackage

// File: rtl/dma_xif_decoder.sv
// Issue channel decoder for the DMA coprocessor.
// Accepts CONF and SET instructions, holds the configuration
// registers and flags a SET-start.

`timescale 1ns/10ps

`include "dma_xif_consts.svh"

module dma_xif_decoder (
  input  logic                        clk_cfg_g,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        issue_valid_i,
  input  dma_xif_pkg::xif_issue_req_t issue_req_i,
  output logic                        issue_ready_o,
  output dma_xif_pkg::xif_issue_rsp_t issue_rsp_o,
  output dma_xif_pkg::dma_cfg_t       cfg_o,
  output logic                        start_cfg_o
);

  import dma_xif_pkg::*;

  logic [`DMA_OPCODE_W-1:0] opcode;
  logic [`DMA_FUNC3_W-1:0]  func3;
  dma_conf_t                conf_fields;
  logic                     is_conf;
  logic                     is_set;
  dma_cfg_t                 cfg_d;
  dma_cfg_t                 cfg_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field extraction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign opcode = issue_req_i.instr[`DMA_OPCODE_OFF +: `DMA_OPCODE_W];
  assign func3  = issue_req_i.instr[`DMA_FUNC3_OFF +: `DMA_FUNC3_W];

  assign conf_fields.direction   = issue_req_i.instr[`DMA_DIRECTION_OFF];
  assign conf_fields.decouple_rw = issue_req_i.instr[`DMA_DEC_RW_OFF];
  assign conf_fields.decouple_aw = issue_req_i.instr[`DMA_DEC_AW_OFF];

  assign is_conf = (opcode == `DMA_CONF_OPCODE);
  assign is_set  = (opcode == `DMA_SET_OPCODE);

  // Same-cycle handshake. Unknown opcodes are left hanging.
  assign issue_ready_o      = issue_valid_i & (is_conf | is_set);
  assign issue_rsp_o.accept = issue_ready_o;

  assign start_cfg_o = issue_ready_o & is_set & (func3 == `DMA_SET_S_FUNC3);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Configuration registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin : cfg_update
    cfg_d = cfg_q;
    if (issue_ready_o && is_conf) begin
      cfg_d.conf = conf_fields;
    end else if (issue_ready_o && issue_req_i.rs_valid) begin
      // SET without a valid operand keeps the old value.
      case (func3)
        `DMA_SET_DA_FUNC3: cfg_d.dst = issue_req_i.rs0;
        `DMA_SET_SA_FUNC3: cfg_d.src = issue_req_i.rs0;
        `DMA_SET_L_FUNC3:  cfg_d.len = issue_req_i.rs0;
        default:           cfg_d     = cfg_q;  // Start and spare codes.
      endcase
    end
  end

  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin : cfg_reg
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (clear_i) begin
      cfg_q <= '0;
    end else begin
      cfg_q <= cfg_d;
    end
  end

  assign cfg_o = cfg_q;

  // A CONF that is taken shows up in the stored options next cycle.
  a_conf_capture : assert property (
    @(posedge clk_cfg_g) disable iff (!rst_ni)
    (issue_rsp_o.accept && is_conf && !clear_i) |=> (cfg_o.conf == $past(conf_fields))
  );

endmodule

// File: rtl/dma_fe_sequencer.sv
// DMA front-end sequencer.
// Writes the stored configuration over the register bus,
// launches the transfer through NEXT_ID and polls for completion.

`timescale 1ns/10ps

`include "dma_xif_consts.svh"

module dma_fe_sequencer (
  input  logic                     clk_cfg_g,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  dma_xif_pkg::dma_cfg_t    cfg_i,
  input  logic                     start_cfg_i,
  output dma_xif_pkg::fe_reg_req_t fe_req_o,
  input  dma_xif_pkg::fe_reg_rsp_t fe_rsp_i,
  output logic                     direction_o,
  output logic                     start_o,
  output logic                     busy_o,
  output logic                     done_o,
  output logic                     error_o
);

  import dma_xif_pkg::*;

  fe_seq_state_e          state_d;
  fe_seq_state_e          state_q;
  logic [`DMA_DATA_W-1:0] id_d;
  logic [`DMA_DATA_W-1:0] id_q;
  dma_cfg_t               cfg_snap_q;  // Configuration seen at launch.
  logic [`DMA_DATA_W-1:0] conf_word;
  logic                   bus_error;
  logic                   zero_id;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request builders
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic fe_reg_req_t wr_req(input logic [`DMA_ADDR_W-1:0] addr,
                                         input logic [`DMA_DATA_W-1:0] data);
    fe_reg_req_t req;
    req.addr  = addr;
    req.write = 1'b1;
    req.wdata = data;
    req.wstrb = '1;
    req.valid = 1'b1;
    return req;
  endfunction

  function automatic fe_reg_req_t rd_req(input logic [`DMA_ADDR_W-1:0] addr);
    fe_reg_req_t req;
    req.addr  = addr;
    req.write = 1'b0;
    req.wdata = '0;
    req.wstrb = '0;
    req.valid = 1'b1;
    return req;
  endfunction

  assign conf_word   = {{(`DMA_DATA_W - $bits(dma_conf_t)){1'b0}}, cfg_snap_q.conf};
  assign direction_o = cfg_i.conf.direction;

  // Snapshot keeps write data steady while SETs keep arriving.
  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin : cfg_snapshot
    if (!rst_ni) begin
      cfg_snap_q <= '0;
    end else if (clear_i) begin
      cfg_snap_q <= '0;
    end else if (state_q == IDLE && start_cfg_i) begin
      cfg_snap_q <= cfg_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequencer FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin : fsm_next
    state_d   = state_q;
    id_d      = id_q;
    fe_req_o  = '0;
    start_o   = 1'b0;
    busy_o    = 1'b0;
    done_o    = 1'b0;
    bus_error = 1'b0;
    zero_id   = 1'b0;

    case (state_q)
      IDLE: begin
        if (start_cfg_i) begin
          state_d = WR_CONF;
        end
      end
      WR_CONF: begin
        fe_req_o = wr_req(`DMA_REG_CONF_OFF, conf_word);
        if (fe_rsp_i.ready) state_d = WR_DST;
      end
      WR_DST: begin
        fe_req_o = wr_req(`DMA_REG_DST_OFF, cfg_snap_q.dst);
        if (fe_rsp_i.ready) state_d = WR_SRC;
      end
      WR_SRC: begin
        fe_req_o = wr_req(`DMA_REG_SRC_OFF, cfg_snap_q.src);
        if (fe_rsp_i.ready) state_d = WR_LEN;
      end
      WR_LEN: begin
        fe_req_o = wr_req(`DMA_REG_LEN_OFF, cfg_snap_q.len);
        if (fe_rsp_i.ready) state_d = START;
      end
      START: begin
        start_o  = 1'b1;
        fe_req_o = rd_req(`DMA_REG_NEXT_ID_OFF);  // Read launches the job.
        if (fe_rsp_i.ready && fe_rsp_i.rdata == '0) begin
          zero_id = 1'b1;  // Front end refused the transfer.
          state_d = IDLE;
        end else if (fe_rsp_i.ready) begin
          id_d    = fe_rsp_i.rdata;
          state_d = BUSY;
        end
      end
      BUSY: begin
        busy_o   = 1'b1;
        fe_req_o = rd_req(`DMA_REG_NEXT_ID_OFF);
        if (fe_rsp_i.ready && fe_rsp_i.rdata != id_q) begin
          state_d = DONE;
        end
      end
      DONE: begin
        done_o  = 1'b1;
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase

    // A bus error aborts from any state with a request out.
    if (fe_req_o.valid && fe_rsp_i.error) begin
      bus_error = 1'b1;
      id_d      = id_q;
      state_d   = IDLE;
    end
  end

  assign error_o = bus_error | zero_id;

  always_ff @(posedge clk_cfg_g or negedge rst_ni) begin : fsm_regs
    if (!rst_ni) begin
      state_q <= IDLE;
      id_q    <= '0;
    end else if (clear_i) begin
      state_q <= IDLE;
      id_q    <= '0;
    end else begin
      state_q <= state_d;
      id_q    <= id_d;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Assertions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_req_stable : assert property (
    @(posedge clk_cfg_g) disable iff (!rst_ni)
    (fe_req_o.valid && !fe_rsp_i.ready && !fe_rsp_i.error && !clear_i)
      |=> (fe_req_o.valid && $stable(fe_req_o.addr) && $stable(fe_req_o.write)
           && $stable(fe_req_o.wdata))
  );

  a_status_onehot : assert property (
    @(posedge clk_cfg_g) disable iff (!rst_ni)
    $onehot0({start_o, busy_o, done_o})
  );

  a_done_pulse : assert property (
    @(posedge clk_cfg_g) disable iff (!rst_ni)
    done_o |=> !done_o
  );

endmodule

// File: rtl/dma_xif_top.sv
// DMA coprocessor instruction decoder top level.
// Connects the issue decoder to the front-end sequencer.

`timescale 1ns/10ps

module dma_xif_top (
  input  logic                        clk_cfg_g,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        issue_valid_i,
  input  dma_xif_pkg::xif_issue_req_t issue_req_i,
  output logic                        issue_ready_o,
  output dma_xif_pkg::xif_issue_rsp_t issue_rsp_o,
  output dma_xif_pkg::fe_reg_req_t    fe_req_o,
  input  dma_xif_pkg::fe_reg_rsp_t    fe_rsp_i,
  output logic                        direction_o,
  output logic                        start_o,
  output logic                        busy_o,
  output logic                        done_o,
  output logic                        error_o
);

  import dma_xif_pkg::*;

  dma_cfg_t cfg;        // Stored configuration.
  logic     start_cfg;  // SET-start accepted.

  dma_xif_decoder u_decoder (
    .clk_cfg_g     (clk_cfg_g),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .issue_valid_i (issue_valid_i),
    .issue_req_i   (issue_req_i),
    .issue_ready_o (issue_ready_o),
    .issue_rsp_o   (issue_rsp_o),
    .cfg_o         (cfg),
    .start_cfg_o   (start_cfg)
  );

  dma_fe_sequencer u_sequencer (
    .clk_cfg_g   (clk_cfg_g),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .cfg_i       (cfg),
    .start_cfg_i (start_cfg),
    .fe_req_o    (fe_req_o),
    .fe_rsp_i    (fe_rsp_i),
    .direction_o (direction_o),
    .start_o     (start_o),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .error_o     (error_o)
  );

endmodule

// File: tb/dma_fe_model.sv
// Behavioral DMA front-end register model.
// Random ready delays, write log, error injection and an advancing transfer ID.

`timescale 1ns/10ps

`include "dma_xif_consts.svh"

module dma_fe_model (
  input  logic                     clk_cfg_g,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  dma_xif_pkg::fe_reg_req_t fe_req_i,
  output dma_xif_pkg::fe_reg_rsp_t fe_rsp_o
);

  import dma_xif_pkg::*;

  // Write log, a ring indexed by the running write count.
  logic [`DMA_ADDR_W-1:0]   log_addr [0:255];
  logic [`DMA_DATA_W-1:0]   log_data [0:255];
  logic [`DMA_DATA_W/8-1:0] log_strb [0:255];
  int                       log_n = 0;
  int                       acc_n = 0;  // Completed accesses.

  // Set from the testbench.
  int                       err_at;
  logic                     force_zero_id;

  int                       seed = 32'h5f99_f8f0;
  int                       r;
  int                       delay = 0;
  int                       polls = 0;
  logic                     launched = 1'b0;
  logic                     clr_seen = 1'b0;
  logic [`DMA_DATA_W-1:0]   cur_id = 32'h0000_0100;  // Fixed nonzero first ID.

  always @(posedge clk_cfg_g) begin
    clr_seen = clear_i;
  end

  always @(negedge clk_cfg_g) begin
    fe_rsp_o = '0;
    if (!rst_ni || clr_seen) begin
      launched = 1'b0;
      delay    = 0;
    end else if (fe_req_i.valid) begin
      if (delay > 0) begin
        delay--;
      end else begin
        fe_rsp_o.ready = 1'b1;
        acc_n++;
        r     = $random(seed);
        delay = r & 3;
        if (err_at == acc_n) begin
          fe_rsp_o.error = 1'b1;  // Injected fault, nothing logged.
        end else if (fe_req_i.write) begin
          log_addr[log_n % 256] = fe_req_i.addr;
          log_data[log_n % 256] = fe_req_i.wdata;
          log_strb[log_n % 256] = fe_req_i.wstrb;
          log_n++;
        end else if (force_zero_id) begin
          fe_rsp_o.rdata = '0;
        end else if (!launched) begin
          launched       = 1'b1;
          r              = $random(seed);
          polls          = ((r & 32'h7fff_ffff) % 5) + 1;
          fe_rsp_o.rdata = cur_id;
        end else if (polls > 0) begin
          polls--;
          fe_rsp_o.rdata = cur_id;
        end else begin
          cur_id++;  // Transfer finished.
          launched       = 1'b0;
          fe_rsp_o.rdata = cur_id;
        end
      end
    end
  end

endmodule

// File: tb/tb_dma_xif_top.sv
// Testbench for the DMA instruction decoder.
// Clock, reset, random instruction stimulus, reference model, checks and watchdog.

`timescale 1ns/10ps

`include "dma_xif_consts.svh"

module tb_dma_xif_top;

  import dma_xif_pkg::*;

  localparam int     N_RAND     = 20;
  localparam int     N_TXN      = N_RAND + 6;
  localparam longint TIMEOUT_NS = N_TXN * 60 * 4;

  logic           clk_cfg_g;
  logic           rst_ni;
  logic           clear_i;
  logic           issue_valid;
  xif_issue_req_t issue_req;
  logic           issue_ready;
  xif_issue_rsp_t issue_rsp;
  fe_reg_req_t    fe_req;
  fe_reg_rsp_t    fe_rsp;
  logic           direction;
  logic           start;
  logic           busy;
  logic           done;
  logic           error;

  int             seed;
  int             log_base;
  int             start_n;
  int             busy_n;
  int             done_n;
  int             err_n;

  // Reference copy of the configuration registers.
  dma_conf_t              m_conf;
  logic [`DMA_DATA_W-1:0] m_dst;
  logic [`DMA_DATA_W-1:0] m_src;
  logic [`DMA_DATA_W-1:0] m_len;

  dma_xif_top dut (
    .clk_cfg_g     (clk_cfg_g),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .issue_valid_i (issue_valid),
    .issue_req_i   (issue_req),
    .issue_ready_o (issue_ready),
    .issue_rsp_o   (issue_rsp),
    .fe_req_o      (fe_req),
    .fe_rsp_i      (fe_rsp),
    .direction_o   (direction),
    .start_o       (start),
    .busy_o        (busy),
    .done_o        (done),
    .error_o       (error)
  );

  dma_fe_model u_fe (
    .clk_cfg_g (clk_cfg_g),
    .rst_ni    (rst_ni),
    .clear_i   (clear_i),
    .fe_req_i  (fe_req),
    .fe_rsp_o  (fe_rsp)
  );

  initial begin
    clk_cfg_g = 1'b0;
    forever #2 clk_cfg_g = ~clk_cfg_g;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the DMA sequence did not finish in time");
    $display("Test failures found");
    $fatal(1);
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else fail_now($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Status monitor, sampled mid low phase
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk_cfg_g) begin
    #1;
    if (rst_ni) begin
      if (start) start_n++;
      if (busy) begin
        assert (start_n > 0) else fail_now("busy_o was raised before start_o");
        busy_n++;
      end
      if (done) done_n++;
      if (fe_req.valid) begin
        assert (err_n == 0) else fail_now("A request was issued after error_o");
      end
      if (fe_req.valid && !fe_req.write) begin
        // Reads only ever target NEXT_ID.
        check_eq("fe_req_o.addr", fe_req.addr, `DMA_REG_NEXT_ID_OFF);
        check_eq("fe_req_o.wstrb", {28'b0, fe_req.wstrb}, 32'd0);
      end
      if (error) err_n++;
    end
  end

  // Drives one instruction and updates the model if it should be taken.
  task automatic send(input logic [31:0] instr, input logic [31:0] rs0, input logic rsv);
    logic [`DMA_OPCODE_W-1:0] op;
    logic                     exp_acc;
    op      = instr[`DMA_OPCODE_OFF +: `DMA_OPCODE_W];
    exp_acc = (op == `DMA_CONF_OPCODE) || (op == `DMA_SET_OPCODE);
    @(negedge clk_cfg_g);
    issue_valid        = 1'b1;
    issue_req.instr    = instr;
    issue_req.rs0      = rs0;
    issue_req.rs_valid = rsv;
    #1;
    check_eq("issue_ready_o", {31'b0, issue_ready}, {31'b0, exp_acc});
    check_eq("issue_rsp_o.accept", {31'b0, issue_rsp.accept}, {31'b0, exp_acc});
    @(posedge clk_cfg_g);
    if (op == `DMA_CONF_OPCODE) begin
      m_conf.direction   = instr[`DMA_DIRECTION_OFF];
      m_conf.decouple_rw = instr[`DMA_DEC_RW_OFF];
      m_conf.decouple_aw = instr[`DMA_DEC_AW_OFF];
    end else if (op == `DMA_SET_OPCODE && rsv) begin
      case (instr[`DMA_FUNC3_OFF +: `DMA_FUNC3_W])
        `DMA_SET_DA_FUNC3: m_dst = rs0;
        `DMA_SET_SA_FUNC3: m_src = rs0;
        `DMA_SET_L_FUNC3:  m_len = rs0;
        default: ;
      endcase
    end
    @(negedge clk_cfg_g);
    issue_valid = 1'b0;  // Also withdraws a refused opcode.
    #1;
    check_eq("direction_o", {31'b0, direction}, {31'b0, m_conf.direction});
  endtask

  task automatic random_config();
    logic [31:0] w;
    logic [31:0] d;
    int          n;
    int          sel;
    n = 4 + (($random(seed) & 32'h7fff_ffff) % 4);
    for (int i = 0; i < n; i++) begin
      w   = $random(seed);
      d   = $random(seed);
      sel = $random(seed) & 7;
      if (sel < 2) begin
        w[6:0] = `DMA_CONF_OPCODE;
      end else if (sel == 5) begin
        while (w[6:0] == `DMA_CONF_OPCODE || w[6:0] == `DMA_SET_OPCODE) w = $random(seed);
      end else begin
        w[6:0]   = `DMA_SET_OPCODE;
        w[14:12] = 3'(($random(seed) & 32'h7fff_ffff) % 3);
      end
      send(w, d, d[0]);
    end
  endtask

  task automatic start_transfer();
    logic [31:0] w;
    start_n  = 0;
    busy_n   = 0;
    done_n   = 0;
    err_n    = 0;
    log_base = u_fe.log_n;
    w        = $random(seed);
    w[6:0]   = `DMA_SET_OPCODE;
    w[14:12] = `DMA_SET_S_FUNC3;
    send(w, $random(seed), w[31]);
  endtask

  task automatic wait_end();
    while (done_n == 0 && err_n == 0) @(posedge clk_cfg_g);
    repeat (8) @(negedge clk_cfg_g);  // Room for stray pulses.
    #1;
    check_eq("fe_req_o.valid", {31'b0, fe_req.valid}, 32'd0);
  endtask

  task automatic check_writes(input int n);
    logic [31:0] exp_addr [0:3];
    logic [31:0] exp_data [0:3];
    int          k;
    exp_addr = '{`DMA_REG_CONF_OFF, `DMA_REG_DST_OFF, `DMA_REG_SRC_OFF, `DMA_REG_LEN_OFF};
    exp_data = '{{29'b0, m_conf}, m_dst, m_src, m_len};
    check_eq("write count", u_fe.log_n - log_base, n);
    for (int i = 0; i < n; i++) begin
      k = (log_base + i) % 256;
      check_eq("fe_req_o.addr", u_fe.log_addr[k], exp_addr[i]);
      check_eq("fe_req_o.wdata", u_fe.log_data[k], exp_data[i]);
      check_eq("fe_req_o.wstrb", {28'b0, u_fe.log_strb[k]}, 32'h0000_000f);
    end
  endtask

  task automatic normal_transfer();
    random_config();
    start_transfer();
    wait_end();
    check_writes(4);
    check_eq("done_o pulses", done_n, 1);
    check_eq("error_o pulses", err_n, 0);
    assert (busy_n > 0) else fail_now("busy_o never rose during a transfer");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int k;
    seed                = 32'h5f99_f8f0;
    rst_ni              = 1'b0;
    clear_i             = 1'b0;
    issue_valid         = 1'b0;
    issue_req           = '0;
    u_fe.err_at         = 0;
    u_fe.force_zero_id  = 1'b0;
    m_conf              = '0;
    m_dst               = '0;
    m_src               = '0;
    m_len               = '0;
    repeat (2) @(posedge clk_cfg_g);
    @(negedge clk_cfg_g);
    rst_ni = 1'b1;

    for (int t = 0; t < N_RAND; t++) normal_transfer();

    // Launch refused with a zero ID.
    random_config();
    u_fe.force_zero_id = 1'b1;
    start_transfer();
    wait_end();
    u_fe.force_zero_id = 1'b0;
    check_writes(4);
    check_eq("error_o pulses", err_n, 1);
    check_eq("busy_o cycles", busy_n, 0);
    check_eq("done_o pulses", done_n, 0);
    normal_transfer();

    // Bus error on one of the four writes.
    random_config();
    k           = 1 + (($random(seed) & 32'h7fff_ffff) % 4);
    u_fe.err_at = u_fe.acc_n + k;
    start_transfer();
    wait_end();
    u_fe.err_at = 0;
    check_writes(k - 1);
    check_eq("error_o pulses", err_n, 1);
    check_eq("done_o pulses", done_n, 0);
    normal_transfer();

    // Clear in the middle of the write phase.
    random_config();
    start_transfer();
    while (u_fe.log_n - log_base < 2) @(posedge clk_cfg_g);
    @(negedge clk_cfg_g);
    clear_i = 1'b1;
    @(negedge clk_cfg_g);
    clear_i = 1'b0;
    m_conf  = '0;
    m_dst   = '0;
    m_src   = '0;
    m_len   = '0;
    #1;
    check_eq("fe_req_o.valid", {31'b0, fe_req.valid}, 32'd0);
    check_eq("status", {28'b0, start, busy, done, error}, 32'd0);
    start_transfer();
    wait_end();
    check_writes(4);
    check_eq("done_o pulses", done_n, 1);
    check_eq("error_o pulses", err_n, 0);

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
rtl/dma_xif_pkg.sv
rtl/dma_xif_decoder.sv
rtl/dma_fe_sequencer.sv
rtl/dma_xif_top.sv
tb/dma_fe_model.sv
tb/tb_dma_xif_top.sv

// File: Makefile
TOOL  ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP   ?= tb_dma_xif_top
FLIST ?= verilog.f
BUILD ?= obj_dir
LOG   ?= sim.log
PASS  := All tests passed!

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
